/* bench/coef_mem_tb.sv */
//==========================================================================
// Coefficient memory testbench
// Random APB traffic against a slot-level model of the store, pointwise
// add and subtract runs, bad accesses and zeroize
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module coef_mem_tb;
    import coef_mem_pkg::*;

    localparam int TIMEOUT_CYCLES = 4000;
    localparam int POLL_LIMIT     = 16;
    localparam int POLY_SLOTS     = BLKS_PER_POLY * COEFS_PER_BLK;
    localparam int A_BASE         = int'(POLY_A_BLK) * COEFS_PER_BLK;
    localparam int B_BASE         = int'(POLY_B_BLK) * COEFS_PER_BLK;
    localparam int C_BASE         = int'(POLY_C_BLK) * COEFS_PER_BLK;

    logic       clk;
    logic       reset_n;
    logic       zeroize;
    logic       psel;
    logic       penable;
    logic       pwrite;
    host_addr_t paddr;
    host_data_t pwdata;
    host_data_t prdata;
    logic       pready;
    logic       pslverr;

    int         seed;
    int         cycle_count = 0;
    host_data_t model_mem [HOST_SLOTS];
    host_addr_t addr;

    tb_clock_gen tb_clock_gen_inst (
        .clk     (clk),
        .reset_n (reset_n)
    );

    coef_mem_top coef_mem_top_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    //======================================================================
    // Failure reporting and random numbers
    //======================================================================

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input host_data_t actual,
                               input host_data_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: %s is 0x%h, expected 0x%h",
                                name, actual, expected));
        end
    endtask

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        logic [31:0] r;
        r = next_rand();
        return r % n;
    endfunction

    function automatic host_data_t rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi, lo};
    endfunction

    //======================================================================
    // Reference model of the host map
    //======================================================================

    function automatic bit addr_unmapped(input host_addr_t a);
        return (a > LAST_POLY_SLOT) && (a < CTRL_REG);
    endfunction

    function automatic bit write_is_bad(input host_addr_t a);
        return addr_unmapped(a) || (a == STATUS_REG);
    endfunction

    function automatic host_data_t model_coef_op(input bit sub, input coef_t a, input coef_t b);
        longint unsigned q;
        longint unsigned r;
        q = longint'(MOD_Q);
        if (sub) begin
            r = (longint'(a) + q - longint'(b)) % q;
        end else begin
            r = (longint'(a) + longint'(b)) % q;
        end
        return host_data_t'(r);
    endfunction

    task automatic model_write(input host_addr_t a, input host_data_t data);
        if (!write_is_bad(a)) begin
            model_mem[a] = data;
            if ((a == ENABLE_REG) && data[0]) begin
                model_mem[STATUS_REG] = '0;
            end
        end
    endtask

    task automatic model_finish_op();
        bit sub;
        sub = model_mem[CTRL_REG][CTRL_OP_SUB_BIT];
        for (int i = 0; i < POLY_SLOTS; i++) begin
            model_mem[C_BASE + i] = model_coef_op(sub, model_mem[A_BASE + i][COEF_W-1:0],
                                                  model_mem[B_BASE + i][COEF_W-1:0]);
        end
        model_mem[STATUS_REG] = host_data_t'(1);
        model_mem[ENABLE_REG] = '0;
    endtask

    task automatic model_clear();
        for (int i = 0; i < HOST_SLOTS; i++) begin
            model_mem[i] = '0;
        end
    endtask

    //======================================================================
    // APB transfers
    //======================================================================

    // Called 1 ns after a rising edge, and returns at the same point
    task automatic apb_write(input host_addr_t a, input host_data_t data, output logic err);
        int waits;
        waits   = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = a;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        while (pready !== 1'b1) begin
            @(posedge clk);
            #1;
            waits = waits + 1;
        end
        // Writes complete in the first access cycle
        check_value("pready wait states on write", host_data_t'(waits), '0);
        err = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input host_addr_t a, output host_data_t data, output logic err);
        int waits;
        waits   = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = a;
        @(posedge clk);
        #1;
        penable = 1'b1;
        while (pready !== 1'b1) begin
            @(posedge clk);
            #1;
            waits = waits + 1;
        end
        // Reads take exactly one wait state
        check_value("pready wait states on read", host_data_t'(waits), host_data_t'(1));
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_and_check(input host_addr_t a, input host_data_t data);
        logic err;
        apb_write(a, data, err);
        check_value($sformatf("pslverr on write to slot %0d", a), host_data_t'(err),
                    host_data_t'(write_is_bad(a)));
        model_write(a, data);
    endtask

    task automatic read_and_check(input host_addr_t a);
        host_data_t data;
        logic       err;
        apb_read(a, data, err);
        check_value($sformatf("pslverr on read of slot %0d", a), host_data_t'(err),
                    host_data_t'(addr_unmapped(a)));
        check_value($sformatf("prdata of slot %0d", a), data,
                    addr_unmapped(a) ? host_data_t'(0) : model_mem[a]);
    endtask

    //======================================================================
    // Pointwise operations
    //======================================================================

    // Slots 0 and 1 carry the wrap cases of both operations
    task automatic fill_operands();
        coef_t a;
        coef_t b;
        for (int i = 0; i < POLY_SLOTS; i++) begin
            a = coef_t'(rand_below(MOD_Q));
            b = coef_t'(rand_below(MOD_Q));
            if (i == 0) begin
                a = MOD_Q - 1;
                b = MOD_Q - 1;
            end else if (i == 1) begin
                a = '0;
                b = MOD_Q - 1;
            end
            write_and_check(host_addr_t'(A_BASE + i), host_data_t'(a));
            write_and_check(host_addr_t'(B_BASE + i), host_data_t'(b));
        end
    endtask

    task automatic start_operation(input bit sub);
        write_and_check(CTRL_REG, host_data_t'(sub));
        write_and_check(ENABLE_REG, host_data_t'(1));
    endtask

    task automatic wait_for_done();
        host_data_t data;
        logic       err;
        int         polls;
        bit         done;
        polls = 0;
        done  = 1'b0;
        while (!done && (polls < POLL_LIMIT)) begin
            apb_read(STATUS_REG, data, err);
            check_value("pslverr on status poll", host_data_t'(err), '0);
            done  = (data == host_data_t'(1));
            polls = polls + 1;
        end
        if (!done) begin
            abort_run("Status was not set within the poll limit after an operation started");
        end
    endtask

    task automatic finish_operation();
        wait_for_done();
        model_finish_op();
        for (int i = 0; i < POLY_SLOTS; i++) begin
            read_and_check(host_addr_t'(C_BASE + i));
        end
        read_and_check(ENABLE_REG);
        read_and_check(STATUS_REG);
    endtask

    //======================================================================
    // Timeout and test sequence
    //======================================================================

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout after %0d cycles, the run did not finish", cycle_count));
        end
    end

    initial begin
        seed    = 32'ha27d_e706;
        zeroize = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        model_clear();

        wait (reset_n === 1'b1);
        check_value("prdata after reset", prdata, '0);
        check_value("pready after reset", host_data_t'(pready), '0);
        check_value("pslverr after reset", host_data_t'(pslverr), '0);

        // Full-word writes and readbacks of polynomial slots and control
        repeat (32) begin
            if (rand_below(8) == 0) begin
                addr = CTRL_REG;
            end else begin
                addr = host_addr_t'(rand_below(int'(LAST_POLY_SLOT) + 1));
            end
            write_and_check(addr, rand_word());
            read_and_check(addr);
        end

        // Pointwise add, then pointwise subtract
        fill_operands();
        start_operation(1'b0);
        finish_operation();
        fill_operands();
        start_operation(1'b1);
        finish_operation();

        // Unmapped slots and the read-only status register
        write_and_check(host_addr_t'(int'(LAST_POLY_SLOT) + 1), rand_word());
        write_and_check(host_addr_t'(int'(CTRL_REG) - 1), rand_word());
        repeat (10) begin
            addr = host_addr_t'(int'(LAST_POLY_SLOT) + 1 +
                                rand_below(int'(CTRL_REG) - int'(LAST_POLY_SLOT) - 1));
            write_and_check(addr, rand_word());
            read_and_check(addr);
        end
        write_and_check(STATUS_REG, rand_word());
        read_and_check(STATUS_REG);
        read_and_check(host_addr_t'(A_BASE));
        read_and_check(host_addr_t'(C_BASE + POLY_SLOTS - 1));

        // A restart clears the old status while the new run is in flight
        read_and_check(STATUS_REG);
        fill_operands();
        start_operation(1'b0);
        read_and_check(STATUS_REG);
        read_and_check(ENABLE_REG);
        finish_operation();

        // Zeroize clears storage and registers
        zeroize = 1'b1;
        @(posedge clk);
        #1;
        zeroize = 1'b0;
        model_clear();
        check_value("pready after zeroize", host_data_t'(pready), '0);
        check_value("pslverr after zeroize", host_data_t'(pslverr), '0);
        repeat (16) begin
            read_and_check(host_addr_t'(rand_below(int'(LAST_POLY_SLOT) + 1)));
        end
        read_and_check(CTRL_REG);
        read_and_check(ENABLE_REG);
        read_and_check(STATUS_REG);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
//==========================================================================
// Testbench clock and reset generator
// 20 ns clock with an active-low reset held for the first five cycles
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset_n
);
    localparam int HALF_PERIOD_NS = 10;
    localparam int RESET_CYCLES   = 5;

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk = ~clk;
        end
    end

    // Release lands just after a rising edge, in step with the stimulus
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

/* coef_store/coef_store.sv */
//==========================================================================
// Coefficient store
// 512 host slots of 64 bits seen by the datapath as packed 96-bit blocks,
// with the control, enable and status registers at the top of the map
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module coef_store (
    input  wire                           clk,
    input  wire                           reset_n,
    input  wire                           zeroize,
    input  wire                           host_wr,
    input  wire                           host_rd,
    input  wire coef_mem_pkg::host_addr_t host_addr,
    input  wire coef_mem_pkg::host_data_t host_wdata,
    output coef_mem_pkg::host_data_t      host_rdata,
    input  wire                           op_rd,
    input  wire coef_mem_pkg::blk_addr_t  a_rd_addr,
    input  wire coef_mem_pkg::blk_addr_t  b_rd_addr,
    output coef_mem_pkg::blk_data_t       a_data,
    output coef_mem_pkg::blk_data_t       b_data,
    input  wire                           blk_wr,
    input  wire coef_mem_pkg::blk_addr_t  blk_wr_addr,
    input  wire coef_mem_pkg::blk_data_t  blk_wr_data,
    input  wire                           op_done,
    output logic                          start_req,
    output logic                          op_sub
);
    import coef_mem_pkg::*;

    host_data_t mem [HOST_SLOTS];

    // Gathers the low coefficient bits of four consecutive slots
    function automatic blk_data_t pack_blk(blk_addr_t addr);
        blk_data_t blk;
        int        base;
        base = int'(addr) * COEFS_PER_BLK;
        for (int k = 0; k < COEFS_PER_BLK; k++) begin
            blk[k*COEF_W +: COEF_W] = mem[base + k][COEF_W-1:0];
        end
        return blk;
    endfunction

    assign start_req = mem[ENABLE_REG][0];
    assign op_sub    = mem[CTRL_REG][CTRL_OP_SUB_BIT];

    //======================================================================
    // Read ports
    //======================================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            host_rdata <= '0;
            a_data     <= '0;
            b_data     <= '0;
        end else if (zeroize) begin
            host_rdata <= '0;
            a_data     <= '0;
            b_data     <= '0;
        end else begin
            // Idle host cycles return zero so the bus sees no stale data
            host_rdata <= host_rd ? mem[host_addr] : '0;
            if (op_rd) begin
                a_data <= pack_blk(a_rd_addr);
                b_data <= pack_blk(b_rd_addr);
            end
        end
    end

    //======================================================================
    // Write ports and register side effects
    //======================================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < HOST_SLOTS; i++) begin
                mem[i] <= '0;
            end
        end else if (zeroize) begin
            for (int i = 0; i < HOST_SLOTS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (host_wr) begin
                mem[host_addr] <= host_wdata;
                // A new start drops the done flag of the previous run
                if ((host_addr == ENABLE_REG) && host_wdata[0]) begin
                    mem[STATUS_REG] <= '0;
                end
            end

            // Assigned after the host write so a block write to the same slot wins
            if (blk_wr) begin
                for (int k = 0; k < COEFS_PER_BLK; k++) begin
                    mem[int'(blk_wr_addr) * COEFS_PER_BLK + k] <=
                        host_data_t'(blk_wr_data[k*COEF_W +: COEF_W]);
                end
            end

            if (op_done) begin
                mem[STATUS_REG] <= host_data_t'(1);
                mem[ENABLE_REG] <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* common/coef_mem_pkg.sv */
//==========================================================================
// Coefficient memory package
// Widths, host address map, modulus and sequencer states shared by the
// APB port, the coefficient store and the polynomial engine
//==========================================================================
`default_nettype none

package coef_mem_pkg;

    typedef logic [8:0]  host_addr_t;
    typedef logic [63:0] host_data_t;
    typedef logic [23:0] coef_t;
    typedef logic [6:0]  blk_addr_t;
    typedef logic [95:0] blk_data_t;

    localparam int HOST_SLOTS    = 512;
    localparam int COEF_W        = $bits(coef_t);
    localparam int COEFS_PER_BLK = 4;
    localparam int BLKS_PER_POLY = 16;

    // Block bases of polynomials A, B and C
    localparam blk_addr_t POLY_A_BLK = 7'd0;
    localparam blk_addr_t POLY_B_BLK = 7'd16;
    localparam blk_addr_t POLY_C_BLK = 7'd32;

    // Register slots at the top of the host map
    localparam host_addr_t LAST_POLY_SLOT = 9'd191;
    localparam host_addr_t CTRL_REG       = 9'd509;
    localparam host_addr_t ENABLE_REG     = 9'd510;
    localparam host_addr_t STATUS_REG     = 9'd511;

    localparam coef_t MOD_Q           = 24'd8380417;
    localparam int    CTRL_OP_SUB_BIT = 0;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUN,
        SEQ_DRAIN,
        SEQ_DONE
    } seq_state_t;

endpackage

`default_nettype wire

/* filelist.f */
common/coef_mem_pkg.sv
rtl/apb_slave_port.sv
coef_store/coef_store.sv
poly_engine/poly_op_sequencer.sv
poly_engine/mod_lane_alu.sv
rtl/coef_mem_top.sv
bench/tb_clock_gen.sv
bench/coef_mem_tb.sv

/* poly_engine/mod_lane_alu.sv */
//==========================================================================
// Four-lane modular ALU
// Adds or subtracts packed coefficient blocks lane by lane modulo q
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module mod_lane_alu (
    input  wire                           clk,
    input  wire                           reset_n,
    input  wire                           op_valid,
    input  wire                           op_sub,
    input  wire coef_mem_pkg::blk_data_t  a_data,
    input  wire coef_mem_pkg::blk_data_t  b_data,
    output coef_mem_pkg::blk_data_t       res_data,
    output logic                          res_valid
);
    import coef_mem_pkg::*;

    blk_data_t lane_res;

    // Both operands sit below q, so one correction step is enough
    function automatic coef_t mod_add(coef_t a, coef_t b);
        logic [COEF_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= {1'b0, MOD_Q}) begin
            sum = sum - {1'b0, MOD_Q};
        end
        return sum[COEF_W-1:0];
    endfunction

    function automatic coef_t mod_sub(coef_t a, coef_t b);
        coef_t diff;
        diff = a - b;
        // On a borrow the wrapped difference plus q lands back in range
        if (a < b) begin
            diff = diff + MOD_Q;
        end
        return diff;
    endfunction

    always_comb begin
        for (int lane = 0; lane < COEFS_PER_BLK; lane++) begin
            lane_res[lane*COEF_W +: COEF_W] = op_sub ?
                mod_sub(a_data[lane*COEF_W +: COEF_W], b_data[lane*COEF_W +: COEF_W]) :
                mod_add(a_data[lane*COEF_W +: COEF_W], b_data[lane*COEF_W +: COEF_W]);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            res_data <= lane_res;
        end
    end

endmodule

`default_nettype wire

/* poly_engine/poly_op_sequencer.sv */
//==========================================================================
// Pointwise operation sequencer
// Walks the 16 blocks of A and B, streams the ALU results into C and
// signals completion to the store
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module poly_op_sequencer (
    input  wire                           clk,
    input  wire                           reset_n,
    input  wire                           zeroize,
    input  wire                           start_req,
    output logic                          op_rd,
    output coef_mem_pkg::blk_addr_t       a_rd_addr,
    output coef_mem_pkg::blk_addr_t       b_rd_addr,
    output logic                          op_valid,
    input  wire                           res_valid,
    input  wire coef_mem_pkg::blk_data_t  res_data,
    output logic                          blk_wr,
    output coef_mem_pkg::blk_addr_t       blk_wr_addr,
    output coef_mem_pkg::blk_data_t       blk_wr_data,
    output logic                          op_done
);
    import coef_mem_pkg::*;

    localparam int               IDX_W    = $clog2(BLKS_PER_POLY);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(BLKS_PER_POLY - 1);

    seq_state_t       state;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             busy;

    assign busy  = (state == SEQ_RUN) || (state == SEQ_DRAIN);
    assign op_rd = (state == SEQ_RUN);

    assign a_rd_addr = POLY_A_BLK + blk_addr_t'(rd_idx);
    assign b_rd_addr = POLY_B_BLK + blk_addr_t'(rd_idx);

    // Results arrive two cycles after their reads, a stray one after zeroize is dropped
    assign blk_wr      = res_valid && busy;
    assign blk_wr_addr = POLY_C_BLK + blk_addr_t'(wr_idx);
    assign blk_wr_data = res_data;

    assign op_done = (state == SEQ_DONE);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= SEQ_IDLE;
            rd_idx   <= '0;
            wr_idx   <= '0;
            op_valid <= 1'b0;
        end else if (zeroize) begin
            state    <= SEQ_IDLE;
            rd_idx   <= '0;
            wr_idx   <= '0;
            op_valid <= 1'b0;
        end else begin
            // Matches the one-cycle read latency of the store
            op_valid <= op_rd;

            // Both indices wrap back to zero after the last block
            if (blk_wr) begin
                wr_idx <= wr_idx + 1'b1;
            end

            case (state)
                SEQ_IDLE: begin
                    if (start_req) begin
                        state <= SEQ_RUN;
                    end
                end
                SEQ_RUN: begin
                    rd_idx <= rd_idx + 1'b1;
                    if (rd_idx == LAST_IDX) begin
                        state <= SEQ_DRAIN;
                    end
                end
                SEQ_DRAIN: begin
                    if (blk_wr && (wr_idx == LAST_IDX)) begin
                        state <= SEQ_DONE;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/apb_slave_port.sv */
//==========================================================================
// APB slave port
// Turns APB transfers into single-cycle host strobes, with zero wait states
// on writes, one wait state on reads and an error for unmapped accesses
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module apb_slave_port (
    input  wire                           clk,
    input  wire                           reset_n,
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire coef_mem_pkg::host_addr_t paddr,
    input  wire coef_mem_pkg::host_data_t pwdata,
    output coef_mem_pkg::host_data_t      prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          host_wr,
    output logic                          host_rd,
    output coef_mem_pkg::host_addr_t      host_addr,
    output coef_mem_pkg::host_data_t      host_wdata,
    input  wire coef_mem_pkg::host_data_t host_rdata
);
    import coef_mem_pkg::*;

    typedef enum logic [1:0] {
        ST_SETUP,
        ST_RD_WAIT,
        ST_RESPOND
    } apb_state_t;

    apb_state_t state;
    logic       setup_phase;
    logic       addr_bad;
    logic       wr_bad;

    assign setup_phase = psel && !penable;

    // The gap between the last polynomial slot and the registers is unmapped
    assign addr_bad = (paddr > LAST_POLY_SLOT) && (paddr < CTRL_REG);
    assign wr_bad   = addr_bad || (paddr == STATUS_REG);

    // APB holds address and write data stable over the whole transfer
    assign host_addr  = paddr;
    assign host_wdata = pwdata;

    // The store drives zero in any cycle that follows no read strobe
    assign prdata = host_rdata;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= ST_SETUP;
            pready  <= 1'b0;
            pslverr <= 1'b0;
            host_wr <= 1'b0;
            host_rd <= 1'b0;
        end else begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            host_wr <= 1'b0;
            host_rd <= 1'b0;
            case (state)
                ST_SETUP: begin
                    // Strobes are set up here so they land in the first access cycle
                    if (setup_phase && pwrite) begin
                        host_wr <= !wr_bad;
                        pready  <= 1'b1;
                        pslverr <= wr_bad;
                        state   <= ST_RESPOND;
                    end else if (setup_phase) begin
                        host_rd <= !addr_bad;
                        state   <= ST_RD_WAIT;
                    end
                end
                ST_RD_WAIT: begin
                    pready  <= 1'b1;
                    pslverr <= addr_bad;
                    state   <= ST_RESPOND;
                end
                default: begin
                    state <= ST_SETUP;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/coef_mem_top.sv */
//==========================================================================
// Coefficient memory top level
// APB host port, coefficient store and pointwise add/subtract engine
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module coef_mem_top (
    input  wire                           clk,
    input  wire                           reset_n,
    input  wire                           zeroize,
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire coef_mem_pkg::host_addr_t paddr,
    input  wire coef_mem_pkg::host_data_t pwdata,
    output coef_mem_pkg::host_data_t      prdata,
    output logic                          pready,
    output logic                          pslverr
);
    import coef_mem_pkg::*;

    // Host side
    logic       host_wr;
    logic       host_rd;
    host_addr_t host_addr;
    host_data_t host_wdata;
    host_data_t host_rdata;

    // Datapath side
    logic       op_rd;
    logic       op_valid;
    logic       res_valid;
    logic       blk_wr;
    logic       op_done;
    logic       start_req;
    logic       op_sub;
    blk_addr_t  a_rd_addr;
    blk_addr_t  b_rd_addr;
    blk_addr_t  blk_wr_addr;
    blk_data_t  a_data;
    blk_data_t  b_data;
    blk_data_t  res_data;
    blk_data_t  blk_wr_data;

    apb_slave_port apb_slave_port_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .host_wr    (host_wr),
        .host_rd    (host_rd),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

    coef_store coef_store_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .host_wr     (host_wr),
        .host_rd     (host_rd),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_rdata  (host_rdata),
        .op_rd       (op_rd),
        .a_rd_addr   (a_rd_addr),
        .b_rd_addr   (b_rd_addr),
        .a_data      (a_data),
        .b_data      (b_data),
        .blk_wr      (blk_wr),
        .blk_wr_addr (blk_wr_addr),
        .blk_wr_data (blk_wr_data),
        .op_done     (op_done),
        .start_req   (start_req),
        .op_sub      (op_sub)
    );

    poly_op_sequencer poly_op_sequencer_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .start_req   (start_req),
        .op_rd       (op_rd),
        .a_rd_addr   (a_rd_addr),
        .b_rd_addr   (b_rd_addr),
        .op_valid    (op_valid),
        .res_valid   (res_valid),
        .res_data    (res_data),
        .blk_wr      (blk_wr),
        .blk_wr_addr (blk_wr_addr),
        .blk_wr_data (blk_wr_data),
        .op_done     (op_done)
    );

    mod_lane_alu mod_lane_alu_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .op_valid  (op_valid),
        .op_sub    (op_sub),
        .a_data    (a_data),
        .b_data    (b_data),
        .res_data  (res_data),
        .res_valid (res_valid)
    );

endmodule

`default_nettype wire
